// File: smArithPkg.sv
`default_nettype none

package smArithPkg;

	// host opcodes
	typedef enum logic [1:0] {
		ADD = 2'd0,
		SUB = 2'd1,
		MUL = 2'd2,
		NEG = 2'd3
	} smOp_t;

	// bit 15 sign, bits 14..0 magnitude
	typedef struct packed {
		logic sign;
		logic [14:0] mag;
	} smWord_t;

	typedef struct packed {
		smOp_t op;
		smWord_t a;
		smWord_t b;
	} smCmd_t;

	// operands already sign-adjusted for the add path
	typedef struct packed {
		logic useMul;
		smWord_t x;
		smWord_t y;
	} smExec_t;

	typedef struct packed {
		smWord_t res;
	} smRsp_t;

	localparam smWord_t smZero = '0;

endpackage

`default_nettype wire

// File: adder15.sv
`timescale 1ns/100ps
`default_nettype none

module adder15 (
	input logic [14:0] in1,
	input logic [14:0] in2,
	input logic sub,
	output logic [14:0] sum,
	output logic cOut
);

	logic [14:0] in2Eff;
	logic [15:0] carry;

	// ones' complement plus carry-in gives in1 - in2
	assign in2Eff = in2 ^ {15{sub}};
	assign carry[0] = sub;

	for (genvar i = 0; i < 15; i++) begin : gRipple
		assign sum[i] = in1[i] ^ in2Eff[i] ^ carry[i];
		assign carry[i + 1] = (in1[i] & in2Eff[i]) | (carry[i] & (in1[i] ^ in2Eff[i]));
	end

	// on subtract, set means no borrow
	assign cOut = carry[15];

endmodule

`default_nettype wire

// File: smMultiply.sv
`timescale 1ns/100ps
`default_nettype none

module smMultiply import smArithPkg::*; (
	input logic clk,
	input logic nRST,
	input smWord_t a,
	input smWord_t b,
	input logic start,
	output smWord_t out,
	output logic finish
);

	typedef enum logic [2:0] {
		IDLE,
		SET,
		CHECKADD,
		ADD,
		FIN
	} mulState_t;

	mulState_t state, nextState;
	logic nextFinish;
	smWord_t nextOut;

	// captured magnitudes and product sign
	logic [14:0] n1, nextN1;
	logic [14:0] n2, nextN2;
	logic diffSign, nextDiffSign;

	// accumulator
	logic [14:0] adderOut;
	logic [14:0] adderSave, nextAdderSave;
	logic [14:0] adderIn, nextAdderIn;

	// iteration counter
	logic [14:0] countOut;
	logic [14:0] countSave, nextCountSave;
	logic [14:0] countIn, nextCountIn;

	// counter has reached n2
	logic stopCount;

	always_ff @(posedge clk, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
			finish <= 1'b0;
		end else begin
			state <= nextState;
			finish <= nextFinish;
		end
	end

	always_ff @(posedge clk) begin
		n1 <= nextN1;
		n2 <= nextN2;
		diffSign <= nextDiffSign;
		countSave <= nextCountSave;
		countIn <= nextCountIn;
		adderSave <= nextAdderSave;
		adderIn <= nextAdderIn;
		out <= nextOut;
	end

	always_comb begin
		nextState = state;
		case (state)
			IDLE: begin
				if (start) begin
					nextState = SET;
				end
			end
			SET: begin
				// zero multiplier skips the loop
				if (b.mag == 15'd0) begin
					nextState = FIN;
				end else begin
					nextState = CHECKADD;
				end
			end
			CHECKADD: begin
				if (stopCount) begin
					nextState = FIN;
				end else begin
					nextState = ADD;
				end
			end
			ADD: begin
				nextState = CHECKADD;
			end
			FIN: begin
				if (!start) begin
					nextState = IDLE;
				end
			end
			default: begin
				nextState = IDLE;
			end
		endcase
	end

	adder15 accAdd (
		.in1(n1),
		.in2(adderIn),
		.sub(1'b0),
		.sum(adderOut),
		.cOut()
	);

	adder15 cntAdd (
		.in1(countIn),
		.in2(15'd1),
		.sub(1'b0),
		.sum(countOut),
		.cOut()
	);

	// countOut - n2 without borrow means countOut >= n2
	adder15 cntCmp (
		.in1(countOut),
		.in2(n2),
		.sub(1'b1),
		.sum(),
		.cOut(stopCount)
	);

	always_comb begin
		nextFinish = 1'b0;
		nextOut = out;
		nextN1 = n1;
		nextN2 = n2;
		nextDiffSign = diffSign;
		nextCountSave = countSave;
		nextCountIn = countIn;
		nextAdderSave = adderSave;
		nextAdderIn = adderIn;

		case (state)
			SET: begin
				nextN1 = a.mag;
				nextN2 = b.mag;
				nextDiffSign = a.sign ^ b.sign;
				nextCountSave = 15'd0;
				nextCountIn = 15'd0;
				nextAdderSave = 15'd0;
				nextAdderIn = 15'd0;
			end
			CHECKADD: begin
				nextCountSave = countOut;
				nextAdderSave = adderOut;
			end
			ADD: begin
				nextCountIn = countSave;
				nextAdderIn = adderSave;
			end
			FIN: begin
				// hold result until start falls
				if (start) begin
					nextOut.sign = diffSign;
					nextOut.mag = adderSave;
					nextFinish = 1'b1;
				end
			end
			default: begin
				nextFinish = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: smAddSub.sv
`timescale 1ns/100ps
`default_nettype none

module smAddSub import smArithPkg::*; (
	input smWord_t x,
	input smWord_t y,
	output smWord_t res
);

	logic xGe;
	logic diffSign;
	logic bigSign;
	logic [14:0] bigMag;
	logic [14:0] smallMag;
	logic [14:0] magOut;

	// x.mag - y.mag, carry out set when x.mag >= y.mag
	adder15 magCmp (
		.in1(x.mag),
		.in2(y.mag),
		.sub(1'b1),
		.sum(),
		.cOut(xGe)
	);

	assign diffSign = x.sign ^ y.sign;

	// order operands so a subtract never goes negative
	assign bigMag = xGe ? x.mag : y.mag;
	assign smallMag = xGe ? y.mag : x.mag;
	assign bigSign = xGe ? x.sign : y.sign;

	adder15 magAdd (
		.in1(bigMag),
		.in2(smallMag),
		.sub(diffSign),
		.sum(magOut),
		.cOut()
	);

	// zero magnitude always comes out as +0
	assign res.mag = magOut;
	assign res.sign = bigSign & (magOut != 15'd0);

endmodule

`default_nettype wire

// File: smDecode.sv
`timescale 1ns/100ps
`default_nettype none

module smDecode import smArithPkg::*; (
	input logic clk,
	input logic nRST,
	input logic req,
	input smCmd_t cmd,
	output logic go,
	output smExec_t exec
);

	logic accept;
	smExec_t nextExec;

	// idle while go is low
	assign accept = req & ~go;

	always_comb begin
		case (cmd.op)
			ADD: begin
				nextExec.useMul = 1'b0;
				nextExec.x = cmd.a;
				nextExec.y = cmd.b;
			end
			SUB: begin
				nextExec.useMul = 1'b0;
				nextExec.x = cmd.a;
				nextExec.y.sign = ~cmd.b.sign;
				nextExec.y.mag = cmd.b.mag;
			end
			NEG: begin
				// -a computed as (-a) + (+0)
				nextExec.useMul = 1'b0;
				nextExec.x.sign = ~cmd.a.sign;
				nextExec.x.mag = cmd.a.mag;
				nextExec.y = smZero;
			end
			default: begin
				nextExec.useMul = 1'b1;
				nextExec.x = cmd.a;
				nextExec.y = cmd.b;
			end
		endcase
	end

	always_ff @(posedge clk, negedge nRST) begin
		if (!nRST) begin
			go <= 1'b0;
		end else if (accept) begin
			go <= 1'b1;
		end else if (go && !req) begin
			go <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			exec <= nextExec;
		end
	end

endmodule

`default_nettype wire

// File: smExecute.sv
`timescale 1ns/100ps
`default_nettype none

module smExecute import smArithPkg::*; (
	input logic clk,
	input logic nRST,
	input logic go,
	input smExec_t exec,
	output logic done,
	output smWord_t res
);

	logic mulStart;
	logic mulFinish;
	smWord_t mulOut;
	smWord_t addOut;
	smWord_t addRes;
	logic addDone;

	// multiplier runs only for MUL commands
	assign mulStart = go & exec.useMul;

	smMultiply mul (
		.clk(clk),
		.nRST(nRST),
		.a(exec.x),
		.b(exec.y),
		.start(mulStart),
		.out(mulOut),
		.finish(mulFinish)
	);

	smAddSub addSub (
		.x(exec.x),
		.y(exec.y),
		.res(addOut)
	);

	// one-cycle add path
	always_ff @(posedge clk, negedge nRST) begin
		if (!nRST) begin
			addDone <= 1'b0;
		end else begin
			addDone <= go & ~exec.useMul;
		end
	end

	always_ff @(posedge clk) begin
		if (go && !exec.useMul && !addDone) begin
			addRes <= addOut;
		end
	end

	// only one path is ever active, so the done flags can be ORed
	assign done = mulFinish | addDone;
	assign res = exec.useMul ? mulOut : addRes;

endmodule

`default_nettype wire

// File: smResult.sv
`timescale 1ns/100ps
`default_nettype none

module smResult import smArithPkg::*; (
	input logic clk,
	input logic nRST,
	input logic done,
	input smWord_t res,
	output logic ack,
	output smRsp_t rsp
);

	logic doneRise;

	// ack still low means this is the first cycle of done
	assign doneRise = done & ~ack;

	always_ff @(posedge clk, negedge nRST) begin
		if (!nRST) begin
			ack <= 1'b0;
		end else begin
			ack <= done;
		end
	end

	// rsp stays put for the whole ack phase
	always_ff @(posedge clk, negedge nRST) begin
		if (!nRST) begin
			rsp <= '0;
		end else if (doneRise) begin
			rsp.res <= res;
		end
	end

endmodule

`default_nettype wire

// File: smArithTop.sv
`timescale 1ns/100ps
`default_nettype none

module smArithTop import smArithPkg::*; (
	input logic clk,
	input logic nRST,
	input logic req,
	input smCmd_t cmd,
	output logic ack,
	output smRsp_t rsp
);

	logic go;
	smExec_t exec;
	logic done;
	smWord_t res;

	smDecode decode (
		.clk(clk),
		.nRST(nRST),
		.req(req),
		.cmd(cmd),
		.go(go),
		.exec(exec)
	);

	smExecute execute (
		.clk(clk),
		.nRST(nRST),
		.go(go),
		.exec(exec),
		.done(done),
		.res(res)
	);

	smResult result (
		.clk(clk),
		.nRST(nRST),
		.done(done),
		.res(res),
		.ack(ack),
		.rsp(rsp)
	);

endmodule

`default_nettype wire

// File: smArithTb.sv
`timescale 1ns/100ps
`default_nettype none

module smArithTb import smArithPkg::*; ();

	// 13 add/sub, 4 neg, 8 mul directed, then 40 + 40 random
	localparam int numCmds = 13 + 4 + 8 + 40 + 40;
	localparam int cycleLimit = numCmds * (2 * 255 + 20) + 4;

	logic clk = 1'b0;
	logic nRST;
	logic req;
	smCmd_t cmd;
	logic ack;
	smRsp_t rsp;

	logic [15:0] lfsrState = 16'd15929;
	smWord_t expVal = '0;
	string curName = "none";
	int mismatches = 0;
	int protoErrs = 0;
	int checked = 0;
	int cycleCount = 0;
	logic prevAck = 1'b0;
	logic prevReq = 1'b0;
	smRsp_t prevRsp = '0;

	smArithTop u_dut (
		.clk(clk),
		.nRST(nRST),
		.req(req),
		.cmd(cmd),
		.ack(ack),
		.rsp(rsp)
	);

	always #2 clk = ~clk;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] nextLfsr(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic takeBits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = nextLfsr(lfsrState);
			v = {v[14:0], lfsrState[0]};
		end
	endtask

	function automatic smWord_t makeWord(input logic s, input int m);
		smWord_t w;
		w.sign = s;
		w.mag = m[14:0];
		return w;
	endfunction

	function automatic string showWord(input smWord_t w);
		return $sformatf("%s%0d", w.sign ? "-" : "+", w.mag);
	endfunction

	// sign-magnitude sum, zero magnitude is always +0
	function automatic smWord_t addSigned(input smWord_t x, input smWord_t y);
		int xm;
		int ym;
		int m;
		logic s;
		xm = x.mag;
		ym = y.mag;
		if (x.sign == y.sign) begin
			m = (xm + ym) % 32768;
			s = x.sign;
		end else if (xm >= ym) begin
			m = xm - ym;
			s = x.sign;
		end else begin
			m = ym - xm;
			s = y.sign;
		end
		if (m == 0) begin
			s = 1'b0;
		end
		return makeWord(s, m);
	endfunction

	function automatic smWord_t expected(input smOp_t op, input smWord_t a, input smWord_t b);
		smWord_t r;
		int prod;
		case (op)
			ADD: r = addSigned(a, b);
			SUB: r = addSigned(a, makeWord(~b.sign, b.mag));
			NEG: r = makeWord(~a.sign & (a.mag != 15'd0), a.mag);
			default: begin
				// product sign kept even for a zero product
				prod = int'(a.mag) * int'(b.mag);
				r = makeWord(a.sign ^ b.sign, prod % 32768);
			end
		endcase
		return r;
	endfunction

	// one full four-phase transfer, entered and left on a falling edge
	task automatic runCmd(input string name, input smOp_t op, input smWord_t a, input smWord_t b);
		expVal = expected(op, a, b);
		curName = name;
		cmd.op = op;
		cmd.a = a;
		cmd.b = b;
		req = 1'b1;
		do @(negedge clk); while (!ack);
		// give the compare process one rising edge with ack high
		@(negedge clk);
		req = 1'b0;
		do @(negedge clk); while (ack);
	endtask

	// samples at the rising edge, before the DUT updates
	always @(posedge clk) begin
		if (ack && !prevAck) begin
			checked++;
			if (!prevReq) begin
				protoErrs++;
				$display("ack rose while req was low during %s", curName);
			end
			if (rsp.res !== expVal) begin
				mismatches++;
				$display("Mismatch %s expected %s actual %s", curName, showWord(expVal),
					showWord(rsp.res));
			end
		end
		if (!ack && prevAck && prevReq) begin
			protoErrs++;
			$display("ack fell while req was still high during %s", curName);
		end
		if (ack && prevAck && rsp !== prevRsp) begin
			protoErrs++;
			$display("rsp changed while ack was high during %s", curName);
		end
		prevAck = ack;
		prevReq = req;
		prevRsp = rsp;
	end

	initial begin : watchdog
		while (cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout after %0d cycles, ack never arrived for %s", cycleCount, curName);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin : stimulus
		logic [15:0] r1;
		logic [15:0] r2;
		logic [15:0] r3;
		nRST = 1'b0;
		req = 1'b0;
		cmd = '0;
		repeat (4) @(negedge clk);
		nRST = 1'b1;
		@(negedge clk);
		if (ack !== 1'b0) begin
			mismatches++;
			$display("Mismatch reset ack expected 0 actual %b", ack);
		end
		if (rsp !== '0) begin
			mismatches++;
			$display("Mismatch reset rsp expected 0000 actual %h", rsp);
		end

		runCmd("add same plus", ADD, makeWord(0, 100), makeWord(0, 200));
		runCmd("add same minus", ADD, makeWord(1, 100), makeWord(1, 200));
		runCmd("add a larger", ADD, makeWord(0, 500), makeWord(1, 200));
		runCmd("add a smaller", ADD, makeWord(0, 200), makeWord(1, 500));
		runCmd("add equal pm", ADD, makeWord(0, 77), makeWord(1, 77));
		runCmd("add equal mp", ADD, makeWord(1, 77), makeWord(0, 77));
		runCmd("add wrap zero", ADD, makeWord(0, 32767), makeWord(0, 1));
		runCmd("add wrap plus", ADD, makeWord(0, 32000), makeWord(0, 1000));
		runCmd("add wrap minus", ADD, makeWord(1, 32000), makeWord(1, 1000));
		runCmd("sub a larger", SUB, makeWord(0, 500), makeWord(0, 200));
		runCmd("sub a smaller", SUB, makeWord(0, 200), makeWord(0, 500));
		runCmd("sub equal", SUB, makeWord(1, 300), makeWord(1, 300));
		runCmd("sub wrap", SUB, makeWord(1, 32767), makeWord(0, 2));

		runCmd("neg plus", NEG, makeWord(0, 1234), makeWord(0, 9));
		runCmd("neg minus", NEG, makeWord(1, 1234), makeWord(1, 9));
		runCmd("neg plus zero", NEG, makeWord(0, 0), makeWord(0, 0));
		runCmd("neg minus zero", NEG, makeWord(1, 0), makeWord(1, 5));

		runCmd("mul b plus zero", MUL, makeWord(0, 5), makeWord(0, 0));
		runCmd("mul b minus zero", MUL, makeWord(0, 5), makeWord(1, 0));
		runCmd("mul neg a b zero", MUL, makeWord(1, 5), makeWord(0, 0));
		runCmd("mul a zero", MUL, makeWord(0, 0), makeWord(0, 10));
		runCmd("mul one by n", MUL, makeWord(0, 1), makeWord(1, 200));
		runCmd("mul n by one", MUL, makeWord(1, 4321), makeWord(0, 1));
		runCmd("mul wrap", MUL, makeWord(0, 300), makeWord(0, 200));
		runCmd("mul wrap max", MUL, makeWord(1, 32767), makeWord(1, 255));

		for (int i = 0; i < 40; i++) begin
			takeBits(1, r1);
			takeBits(16, r2);
			takeBits(16, r3);
			runCmd($sformatf("rand addsub %0d", i), r1[0] ? SUB : ADD, smWord_t'(r2),
				smWord_t'(r3));
		end
		// 8-bit multiplier keeps the loop short
		for (int i = 0; i < 40; i++) begin
			takeBits(16, r2);
			takeBits(1, r1);
			takeBits(8, r3);
			runCmd($sformatf("rand mul %0d", i), MUL, smWord_t'(r2),
				makeWord(r1[0], int'(r3[7:0])));
		end

		@(negedge clk);
		if (checked != numCmds) begin
			protoErrs++;
			$display("only %0d of %0d commands were answered", checked, numCmds);
		end
		$display("errors: %0d mismatches, %0d handshake, %0d responses checked",
			mismatches, protoErrs, checked);
		if (mismatches == 0 && protoErrs == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
smArithPkg.sv
adder15.sv
smMultiply.sv
smAddSub.sv
smDecode.sv
smExecute.sv
smResult.sv
smArithTop.sv
smArithTb.sv

// File: Bender.yml
package:
  name: smArith

sources:
  - smArithPkg.sv
  - adder15.sv
  - smMultiply.sv
  - smAddSub.sv
  - smDecode.sv
  - smExecute.sv
  - smResult.sv
  - smArithTop.sv
  - target: simulation
    files:
      - smArithTb.sv
